//--- Bender.yml
package:
  name: outputPortSwitch

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/nocPkg.sv
      - hdl/inputBuffer.sv
      - hdl/packetTimer.sv
      - hdl/outputArbiter.sv
      - hdl/outputPortSwitch.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verification/outputPortSwitchTb.sv

//--- hdl/inputBuffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "nocSettings.svh"

module inputBuffer (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flitT  inFlit,
  input  logic          inValid,
  output logic          inReady,
  output nocPkg::flitT  headFlit,
  output logic          headValid,
  input  logic          headReady
);

  import nocPkg::*;

  localparam int Depth = `NOC_FIFO_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  localparam logic [PtrW:0]   FullCount = (PtrW + 1)'(Depth);
  localparam logic [PtrW-1:0] LastPtr   = PtrW'(Depth - 1);

  flitT            mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0]   count;
  logic            push;
  logic            pop;

  // Pointers wrap at the last entry, so the depth need not be a power of two
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] result;
    if (ptr == LastPtr)
      result = '0;
    else
      result = ptr + 1'b1;
    return result;
  endfunction

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  // A full buffer refuses a push even when the head leaves in the same cycle
  assign inReady   = (count != FullCount);
  assign headValid = (count != '0);
  assign headFlit  = mem[rdPtr];

  assign push = inValid && inReady;
  assign pop  = headValid && headReady;

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

endmodule

`default_nettype wire

//--- hdl/nocPkg.sv
`default_nettype none

`include "nocSettings.svh"

package nocPkg;

  // Flit kind, one-hot
  typedef enum logic [`NOC_ID_W-1:0]
  {
    HEAD = 3'b001,
    BODY = 3'b010,
    TAIL = 3'b100
  } flitIdE;

  // Header view of the payload
  // Length counts every flit of the packet, the header included
  typedef struct packed
  {
    logic [`NOC_DEST_W-1:0]   dest;
    logic [`NOC_LENGTH_W-1:0] length;
  } headerFieldsT;

  // The same payload word read as a header or as plain data
  typedef union packed
  {
    headerFieldsT               header;
    logic [`NOC_PAYLOAD_W-1:0]  data;
  } payloadU;

  typedef struct packed
  {
    flitIdE  id;
    payloadU payload;
  } flitT;

  // Bit order is Local, North, East, West, South from bit 0 up
  typedef logic [`NOC_PORTS-1:0] portMaskT;

endpackage

`default_nettype wire

//--- hdl/nocSettings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Router geometry, one output port fed by this many inputs
`define NOC_PORTS 5

// Input buffer depth in flits
`define NOC_FIFO_DEPTH 4

// Flit id is a one-hot code
`define NOC_ID_W 3

// Payload and its header view
`define NOC_PAYLOAD_W 16
`define NOC_DEST_W 4
`define NOC_LENGTH_W 12

`endif

//--- hdl/outputArbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "nocSettings.svh"

module outputArbiter (
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::flitT      headFlit [`NOC_PORTS],
  input  nocPkg::portMaskT  headValid,
  output nocPkg::portMaskT  headReady,
  output nocPkg::flitT      outFlit,
  output logic              outValid,
  input  logic              outReady
);

  import nocPkg::*;

  localparam int Ports = `NOC_PORTS;
  localparam int IdxW  = $clog2(Ports);

  localparam logic [IdxW-1:0] LastIdx = IdxW'(Ports - 1);

  portMaskT        grant;
  portMaskT        nextGrant;
  portMaskT        request;
  portMaskT        transfer;
  wire portMaskT   lastFlit;
  logic [IdxW-1:0] grantIdx;
  logic [IdxW-1:0] searchStart;
  logic            idle;
  logic            packetDone;

  // First requesting port found when walking upward from start, with wrap
  function automatic portMaskT pickFirst(
    input portMaskT        req,
    input logic [IdxW-1:0] start
  );
    portMaskT pick;
    int       idx;
    pick = '0;
    for (int i = 0; i < Ports; i++)
    begin
      idx = (int'(start) + i) % Ports;
      if (req[idx] && (pick == '0))
        pick[idx] = 1'b1;
    end
    return pick;
  endfunction

  // Index of the set bit in a one-hot mask, zero when the mask is empty
  function automatic logic [IdxW-1:0] maskToIdx(input portMaskT mask);
    logic [IdxW-1:0] idx;
    idx = '0;
    for (int i = 0; i < Ports; i++)
    begin
      if (mask[i])
        idx = IdxW'(i);
    end
    return idx;
  endfunction

  //////////////////////////////
  // Grant state
  //////////////////////////////

  assign idle       = (grant == '0);
  assign grantIdx   = maskToIdx(grant);
  assign packetDone = |(transfer & lastFlit);

  // From idle the search begins at Local, otherwise just past the current holder
  always_comb
  begin
    if (idle || (grantIdx == LastIdx))
      searchStart = '0;
    else
      searchStart = grantIdx + 1'b1;
  end

  // The finishing port still shows the flit now leaving, so it sits out this pick
  assign request = headValid & ~grant;

  always_comb
  begin
    nextGrant = grant;
    if (idle || packetDone)
      nextGrant = pickFirst(request, searchStart);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= '0;
    else
      grant <= nextGrant;
  end

  //////////////////////////////
  // Flit path
  //////////////////////////////

  assign transfer  = grant & headValid & {Ports{outReady}};
  assign headReady = grant & {Ports{outReady}};

  assign outValid = |(grant & headValid);
  assign outFlit  = headFlit[grantIdx];

  // One timer per input tracks how far its packet has gone
  for (genvar p = 0; p < Ports; p++)
  begin : genTimer
    packetTimer i_packetTimer (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[p]),
      .transfer (transfer[p]),
      .lastFlit (lastFlit[p])
    );
  end

endmodule

`default_nettype wire

//--- hdl/outputPortSwitch.sv
`timescale 1ns/10ps
`default_nettype none

`include "nocSettings.svh"

module outputPortSwitch (
  input  logic                  clk,
  input  logic                  rst,
  input  nocPkg::flitT          portFlit [`NOC_PORTS],
  input  nocPkg::portMaskT      portValid,
  output wire nocPkg::portMaskT portReady,
  output nocPkg::flitT          outFlit,
  output logic                  outValid,
  input  logic                  outReady
);

  import nocPkg::*;

  wire flitT     headFlit [`NOC_PORTS];
  wire portMaskT headValid;
  wire portMaskT headReady;

  // One buffer per input port, in Local, North, East, West, South order
  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : genBuffer
    inputBuffer i_inputBuffer (
      .clk       (clk),
      .rst       (rst),
      .inFlit    (portFlit[p]),
      .inValid   (portValid[p]),
      .inReady   (portReady[p]),
      .headFlit  (headFlit[p]),
      .headValid (headValid[p]),
      .headReady (headReady[p])
    );
  end

  outputArbiter i_outputArbiter (
    .clk       (clk),
    .rst       (rst),
    .headFlit  (headFlit),
    .headValid (headValid),
    .headReady (headReady),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outReady  (outReady)
  );

endmodule

`default_nettype wire

//--- hdl/packetTimer.sv
`timescale 1ns/10ps
`default_nettype none

`include "nocSettings.svh"

module packetTimer (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flitT  headFlit,
  input  logic          transfer,
  output logic          lastFlit
);

  import nocPkg::*;

  localparam int LenW = `NOC_LENGTH_W;

  logic [LenW-1:0] pktLength;
  logic [LenW-1:0] flitCount;
  logic [LenW-1:0] nextCount;
  logic            isHead;
  logic            headOnly;

  assign isHead    = (headFlit.id == HEAD);
  assign nextCount = flitCount + 1'b1;

  // A header with length zero is closed like a one flit packet
  assign headOnly = isHead && (headFlit.payload.header.length <= LenW'(1));

  // Count holds the flits already sent, so the flit in flight is number count plus one
  assign lastFlit = transfer && (isHead ? headOnly : (nextCount == pktLength));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLength <= '0;
      flitCount <= '0;
    end
    else if (transfer)
    begin
      if (isHead)
      begin
        pktLength <= headFlit.payload.header.length;
        flitCount <= LenW'(1);
      end
      else
      begin
        flitCount <= nextCount;
      end
    end
  end

endmodule

`default_nettype wire

//--- outputPortSwitch.f
+incdir+hdl
hdl/nocPkg.sv
hdl/inputBuffer.sv
hdl/packetTimer.sv
hdl/outputArbiter.sv
hdl/outputPortSwitch.sv
verification/outputPortSwitchTb.sv

//--- verification/outputPortSwitchTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "nocSettings.svh"

module outputPortSwitchTb;

  import nocPkg::*;

  localparam int Ports   = `NOC_PORTS;
  localparam int Depth   = `NOC_FIFO_DEPTH;
  localparam int Timeout = 200;
  localparam int Slots   = 128;

  logic     clk;
  logic     rst;
  flitT     portFlit [Ports];
  portMaskT portValid;
  portMaskT portReady;
  flitT     outFlit;
  logic     outValid;
  logic     outReady;

  // Expected flits per input port, written by the driver and read by the checker
  flitT expFlit [Ports][Slots];
  int   expWr [Ports];
  int   expRd [Ports];
  int   stallCount [Ports];
  int   flitGap [Ports];
  flitT outLog [$];
  int   tagSeq;
  int   errors;
  int   timeouts;

  outputPortSwitch i_outputPortSwitch (
    .clk       (clk),
    .rst       (rst),
    .portFlit  (portFlit),
    .portValid (portValid),
    .portReady (portReady),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outReady  (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Inputs settle 1 ns after the rising edge, so the falling edge sees a full transfer
  always @(negedge clk)
  begin
    if (!rst && outValid && outReady)
      outLog.push_back(outFlit);
  end

  //////////////////////////////
  // Driver and checker
  //////////////////////////////

  task automatic sendPacket(input int port, input int len);
    flitT f;
    int   t;
    stallCount[port] = 0;
    for (int i = 0; i < len; i++)
    begin
      if (i == 0)
      begin
        f.id = HEAD;
        f.payload.header.dest   = port[`NOC_DEST_W-1:0];
        f.payload.header.length = len[`NOC_LENGTH_W-1:0];
      end
      else
      begin
        f.id = (i == len - 1) ? TAIL : BODY;
        f.payload.data = {port[`NOC_DEST_W-1:0], tagSeq[`NOC_LENGTH_W-1:0]};
        tagSeq++;
      end
      expFlit[port][expWr[port]] = f;
      expWr[port]++;
      portFlit[port]  = f;
      portValid[port] = 1'b1;
      t = 0;
      while (!portReady[port] && t < Timeout)
      begin
        @(posedge clk);
        #1;
        t++;
        stallCount[port]++;
      end
      if (!portReady[port])
      begin
        $display("Port %0d did not accept a flit in time", port);
        timeouts++;
        portValid[port] = 1'b0;
        return;
      end
      @(posedge clk);
      #1;
      // A slow sender leaves idle cycles, so its buffer can run dry mid packet
      if (flitGap[port] > 0 && i < len - 1)
      begin
        portValid[port] = 1'b0;
        repeat (flitGap[port]) @(posedge clk);
        #1;
      end
    end
    portValid[port] = 1'b0;
  endtask

  // A negative port takes whichever packet comes next and finds its port from the header
  task automatic checkNextPacket(input int port);
    flitT got;
    flitT exp;
    int   p;
    int   len;
    int   t;
    p   = port;
    len = 1;
    for (int i = 0; i < len; i++)
    begin
      t = 0;
      while (outLog.size() == 0 && t < Timeout)
      begin
        @(posedge clk);
        #1;
        t++;
      end
      if (outLog.size() == 0)
      begin
        $display("No output flit arrived in time");
        timeouts++;
        return;
      end
      got = outLog.pop_front();
      if (p < 0)
        p = int'(got.payload.header.dest) % Ports;
      assert (expRd[p] < expWr[p])
      else
      begin
        $display("Output flit for port %0d came with nothing left to send", p);
        errors++;
      end
      if (expRd[p] >= expWr[p])
        return;
      exp = expFlit[p][expRd[p]];
      expRd[p]++;
      if (i == 0)
        len = int'(exp.payload.header.length);
      assert (got.id == exp.id)
      else
      begin
        $display("FAILED outFlit.id: got %h, expected %h", got.id, exp.id);
        errors++;
      end
      assert (got.payload == exp.payload)
      else
      begin
        $display("FAILED outFlit.payload: got %h, expected %h", got.payload, exp.payload);
        errors++;
      end
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic checkResetState();
    assert (outValid == 1'b0)
    else
    begin
      $display("FAILED outValid: got %h, expected %h", outValid, 1'b0);
      errors++;
    end
    assert (portReady == '1)
    else
    begin
      $display("FAILED portReady: got %h, expected %h", portReady, {Ports{1'b1}});
      errors++;
    end
  endtask

  task automatic forwardSinglePackets();
    sendPacket(1, 4);
    checkNextPacket(1);
    sendPacket(0, 1);
    checkNextPacket(0);
  endtask

  // Every head flit lands on the same edge, so the first grant sees all five
  task automatic loadAllPortsAtOnce();
    fork
      sendPacket(0, 2);
      sendPacket(1, 3);
      sendPacket(2, 4);
      sendPacket(3, 5);
      sendPacket(4, 1);
    join
    for (int p = 0; p < Ports; p++)
      checkNextPacket(p);
  endtask

  // East pauses after each flit, so Local and South wait while its buffer is empty
  task automatic rotateAfterEast();
    flitGap[2] = 1;
    fork
      sendPacket(2, 10);
      begin
        repeat (3) @(posedge clk);
        #1;
        fork
          sendPacket(0, 2);
          sendPacket(4, 3);
        join
      end
    join
    flitGap[2] = 0;
    checkNextPacket(2);
    checkNextPacket(4);
    checkNextPacket(0);
  endtask

  task automatic stressWithBackPressure();
    bit sendDone;
    sendDone = 1'b0;
    fork
      begin
        fork
          begin
            sendPacket(0, 6);
            sendPacket(0, 2);
          end
          sendPacket(1, 3);
          begin
            sendPacket(2, 5);
            sendPacket(2, 1);
          end
          sendPacket(3, 7);
          sendPacket(4, 4);
        join
        sendDone = 1'b1;
      end
      for (int i = 0; i < 4 * Timeout && !sendDone; i++)
      begin
        @(posedge clk);
        #1;
        outReady = ($urandom % 2) != 0;
      end
    join
    outReady = 1'b1;
    for (int k = 0; k < 7; k++)
      checkNextPacket(-1);
  endtask

  // Nothing drains, so West takes exactly one buffer of flits without a stall
  task automatic fillWhileBlocked();
    outReady = 1'b0;
    sendPacket(3, Depth);
    assert (stallCount[3] == 0)
    else
    begin
      $display("West stalled before its buffer was full");
      errors++;
    end
    assert (portReady[3] == 1'b0)
    else
    begin
      $display("FAILED portReady[3]: got %h, expected %h", portReady[3], 1'b0);
      errors++;
    end
    outReady = 1'b1;
    checkNextPacket(3);
  endtask

  initial
  begin
    void'($urandom(32'hc8d3));
    rst       = 1'b1;
    portValid = '0;
    outReady  = 1'b0;
    tagSeq    = 0;
    errors    = 0;
    timeouts  = 0;
    for (int p = 0; p < Ports; p++)
    begin
      portFlit[p] = '0;
      expWr[p]    = 0;
      expRd[p]    = 0;
      flitGap[p]  = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    checkResetState();
    outReady = 1'b1;
    forwardSinglePackets();
    loadAllPortsAtOnce();
    rotateAfterEast();
    stressWithBackPressure();
    fillWhileBlocked();
    repeat (4) @(posedge clk);
    assert (outLog.size() == 0)
    else
    begin
      $display("%0d output flits were never sent", outLog.size());
      errors++;
    end
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
